// File: common/fpWbPkg.sv
// FP write-back shared definitions
// Widths, counts, result and recovery structs and the active list
// execution state used by the write stage, register file and active list

package fpWbPkg;

    // Results handled per cycle
    localparam int ISSUE_WIDTH = 2;

    // Physical FP register file
    localparam int PHY_REG_NUM  = 64;
    localparam int PHY_REG_BITS = 6;

    // Active list
    localparam int AL_ENTRY_NUM = 32;
    localparam int AL_PTR_BITS  = 5;

    // FP data path
    localparam int FLEN = 64;

    typedef logic [PHY_REG_BITS-1:0] phyRegNum;
    typedef logic [AL_PTR_BITS-1:0]  alPtr;
    typedef logic [FLEN-1:0]         fpData;

    // Per-entry state kept in the active list
    typedef enum logic {
        EXEC_NOT_FINISHED = 1'b0,
        EXEC_SUCCESS      = 1'b1
    } execState;

    // One issued result from an FP execution pipe
    typedef struct packed {
        logic     valid;
        logic     writeReg;
        phyRegNum phyDst;
        alPtr     alIndex;
        logic     dataValid;
        fpData    data;
    } fpResult;

    // Selective flush range with inclusive head and exclusive tail
    typedef struct packed {
        logic inRecovery;
        alPtr flushHead;
        alPtr flushTail;
    } recoveryInfo;

endpackage : fpWbPkg

// File: fpRegWrite/flushRangeDetector.sv
// Selective flush detector
// Flags an active list pointer that falls inside the circular
// flush range while recovery is in progress

`timescale 1ns/10ps

module flushRangeDetector
    import fpWbPkg::*;
(
    input  recoveryInfo recovery,
    input  alPtr        index,
    output logic        flush
);

    logic afterHead;
    logic beforeTail;
    logic wraps;

    always_comb begin
        afterHead  = (index >= recovery.flushHead);
        beforeTail = (index < recovery.flushTail);
        wraps      = (recovery.flushHead > recovery.flushTail);

        if (!recovery.inRecovery) begin
            flush = 1'b0;
        end else if (wraps) begin
            // Range runs past the last entry back to zero
            flush = afterHead || beforeTail;
        end else begin
            // Equal head and tail leaves nothing in range
            flush = afterHead && beforeTail;
        end
    end

endmodule : flushRangeDetector

// File: fpRegWrite/fpRegWriteStage.sv
// FP register write stage
// Holds the issued FP results for one cycle and turns the survivors
// into register file writes and active list completion writes

`timescale 1ns/10ps

module fpRegWriteStage
    import fpWbPkg::*;
(
    input  logic        ctrl,
    input  logic        rst,
    input  logic        stall,
    input  logic        clear,
    input  fpResult     results [ISSUE_WIDTH],
    input  recoveryInfo recovery,
    output logic        regWe   [ISSUE_WIDTH],
    output phyRegNum    regNum  [ISSUE_WIDTH],
    output fpData       regData [ISSUE_WIDTH],
    output logic        alWe    [ISSUE_WIDTH],
    output alPtr        alIndex [ISSUE_WIDTH],
    output execState    alState [ISSUE_WIDTH]
);

    fpResult pipeReg [ISSUE_WIDTH];
    logic    flush   [ISSUE_WIDTH];
    logic    update  [ISSUE_WIDTH];

    // Stage register holding one result per slot
    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipeReg <= results;
        end
    end

    // One flush check per slot against this cycle's recovery range
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : gFlush
        flushRangeDetector i_flushRangeDetector (
            .recovery (recovery),
            .index    (pipeReg[i].alIndex),
            .flush    (flush[i])
        );
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            update[i] = pipeReg[i].valid && !stall && !clear && !flush[i];

            // Register file port
            regWe[i]   = update[i] && pipeReg[i].writeReg;
            regNum[i]  = pipeReg[i].phyDst;
            regData[i] = pipeReg[i].data;

            // Active list completion port
            alWe[i]    = update[i];
            alIndex[i] = pipeReg[i].alIndex;
            if (pipeReg[i].dataValid) begin
                alState[i] = EXEC_SUCCESS;
            end else begin
                alState[i] = EXEC_NOT_FINISHED;
            end
        end
    end

    // Rename never hands the same destination to two results in flight together
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : gDstCheckA
        for (genvar j = i + 1; j < ISSUE_WIDTH; j++) begin : gDstCheckB
            assert property (@(posedge ctrl) disable iff (rst)
                !(regWe[i] && regWe[j] && (regNum[i] == regNum[j])))
            else $error("slots %0d and %0d write the same FP register", i, j);
        end
    end

endmodule : fpRegWriteStage

// File: src/fpPhyRegFile.sv
// Physical FP register file
// ISSUE_WIDTH write ports applied at the clock edge, higher slots last,
// and one combinational read port

`timescale 1ns/10ps

module fpPhyRegFile
    import fpWbPkg::*;
(
    input  logic     ctrl,
    input  logic     rst,
    input  logic     we     [ISSUE_WIDTH],
    input  phyRegNum wrNum  [ISSUE_WIDTH],
    input  fpData    wrData [ISSUE_WIDTH],
    input  phyRegNum rdNum,
    output fpData    rdData
);

    fpData regs [PHY_REG_NUM];

    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int r = 0; r < PHY_REG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later slots win on a shared index
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (we[i]) begin
                    regs[wrNum[i]] <= wrData[i];
                end
            end
        end
    end

    // A write shows up on the read port right after its edge
    assign rdData = regs[rdNum];

endmodule : fpPhyRegFile

// File: src/activeListExecState.sv
// Active list execution state array
// One state per entry, cleared on allocation and updated by
// completion writes; a query port reads it combinationally

`timescale 1ns/10ps

module activeListExecState
    import fpWbPkg::*;
(
    input  logic     ctrl,
    input  logic     rst,
    input  logic     allocValid,
    input  alPtr     allocIndex,
    input  logic     we      [ISSUE_WIDTH],
    input  alPtr     wrIndex [ISSUE_WIDTH],
    input  execState wrState [ISSUE_WIDTH],
    input  alPtr     queryIndex,
    output execState queryState
);

    execState state [AL_ENTRY_NUM];

    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int e = 0; e < AL_ENTRY_NUM; e++) begin
                state[e] <= EXEC_NOT_FINISHED;
            end
        end else begin
            if (allocValid) begin
                state[allocIndex] <= EXEC_NOT_FINISHED;
            end
            // Completions go after allocation
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (we[i]) begin
                    state[wrIndex[i]] <= wrState[i];
                end
            end
        end
    end

    assign queryState = state[queryIndex];

    // An entry cannot be allocated while one of its results is writing back
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : gAllocCheck
        assert property (@(posedge ctrl) disable iff (rst)
            !(allocValid && we[i] && (wrIndex[i] == allocIndex)))
        else $error("allocation collides with completion on slot %0d", i);
    end

endmodule : activeListExecState

// File: src/fpWritebackTop.sv
// FP write-back top level
// Connects the write stage to the physical FP register file and
// to the active list execution state array

`timescale 1ns/10ps

module fpWritebackTop
    import fpWbPkg::*;
(
    input  logic        ctrl,
    input  logic        rst,
    input  logic        stall,
    input  logic        clear,
    input  fpResult     results [ISSUE_WIDTH],
    input  recoveryInfo recovery,
    input  logic        allocValid,
    input  alPtr        allocIndex,
    input  phyRegNum    readNum,
    input  alPtr        queryIndex,
    output fpData       readData,
    output execState    queryState
);

    logic     regWe   [ISSUE_WIDTH];
    phyRegNum regNum  [ISSUE_WIDTH];
    fpData    regData [ISSUE_WIDTH];
    logic     alWe    [ISSUE_WIDTH];
    alPtr     alIndex [ISSUE_WIDTH];
    execState alState [ISSUE_WIDTH];

    fpRegWriteStage i_fpRegWriteStage (
        .ctrl     (ctrl),
        .rst      (rst),
        .stall    (stall),
        .clear    (clear),
        .results  (results),
        .recovery (recovery),
        .regWe    (regWe),
        .regNum   (regNum),
        .regData  (regData),
        .alWe     (alWe),
        .alIndex  (alIndex),
        .alState  (alState)
    );

    fpPhyRegFile i_fpPhyRegFile (
        .ctrl   (ctrl),
        .rst    (rst),
        .we     (regWe),
        .wrNum  (regNum),
        .wrData (regData),
        .rdNum  (readNum),
        .rdData (readData)
    );

    activeListExecState i_activeListExecState (
        .ctrl       (ctrl),
        .rst        (rst),
        .allocValid (allocValid),
        .allocIndex (allocIndex),
        .we         (alWe),
        .wrIndex    (alIndex),
        .wrState    (alState),
        .queryIndex (queryIndex),
        .queryState (queryState)
    );

endmodule : fpWritebackTop

// File: test/tbFpWriteback.sv
// FP write-back testbench
// Directed and random FP results into the write-back top level, with
// register and active list readback checked against a reference model

`timescale 1ns/10ps

module tbFpWriteback
    import fpWbPkg::*;
();

    localparam int RANDOM_CYCLES = 2000;
    localparam int MAX_CYCLES    = 5000;

    logic        ctrl;
    logic        rst;
    logic        stall;
    logic        clear;
    fpResult     results [ISSUE_WIDTH];
    recoveryInfo recovery;
    logic        allocValid;
    alPtr        allocIndex;
    phyRegNum    readNum;
    alPtr        queryIndex;
    fpData       readData;
    execState    queryState;

    // Reference model with refHeld mirroring the stage register
    fpData    refRegs  [PHY_REG_NUM];
    execState refState [AL_ENTRY_NUM];
    fpResult  refHeld  [ISSUE_WIDTH];
    phyRegNum lastReg;
    alPtr     lastEntry;
    integer   seed;
    int       errors;
    int       checks;

    fpWritebackTop i_dut (
        .ctrl       (ctrl),
        .rst        (rst),
        .stall      (stall),
        .clear      (clear),
        .results    (results),
        .recovery   (recovery),
        .allocValid (allocValid),
        .allocIndex (allocIndex),
        .readNum    (readNum),
        .queryIndex (queryIndex),
        .readData   (readData),
        .queryState (queryState)
    );

    initial begin
        ctrl = 1'b0;
        forever #5 ctrl = ~ctrl;
    end

    initial begin
        for (int t = 0; t < MAX_CYCLES; t++) begin
            #10;
        end
        $display("Timeout: the test did not finish within %0d clock periods", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // Flushed when the offset from head is below the range length
    function automatic logic inFlushRange(recoveryInfo rec, alPtr idx);
        alPtr offset;
        alPtr span;
        offset = idx - rec.flushHead;
        span   = rec.flushTail - rec.flushHead;
        return rec.inRecovery && (offset < span);
    endfunction

    function automatic logic slotUpdates(fpResult r, logic stallIn, logic clearIn,
                                         recoveryInfo rec);
        return r.valid && !stallIn && !clearIn && !inFlushRange(rec, r.alIndex);
    endfunction

    function automatic fpResult makeResult(logic wr, phyRegNum dst, alPtr idx, logic dv,
                                           fpData d);
        fpResult r;
        r.valid     = 1'b1;
        r.writeReg  = wr;
        r.phyDst    = dst;
        r.alIndex   = idx;
        r.dataValid = dv;
        r.data      = d;
        return r;
    endfunction

    function automatic logic completesAt(alPtr idx);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (refHeld[s].valid && (refHeld[s].alIndex == idx)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s mismatch, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic idleInputs();
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            results[s] = '0;
        end
        stall      = 1'b0;
        clear      = 1'b0;
        recovery   = '0;
        allocValid = 1'b0;
        allocIndex = '0;
    endtask

    task automatic step();
        @(negedge ctrl);
    endtask

    task automatic readBack(input phyRegNum num, input alPtr idx);
        idleInputs();
        readNum    = num;
        queryIndex = idx;
        step();
    endtask

    // Present a pair, then flush against the given range in the write cycle
    task automatic recoveryCase(input alPtr head, input alPtr tail, input alPtr idx0,
                                input phyRegNum dst0, input alPtr idx1, input phyRegNum dst1);
        idleInputs();
        results[0] = makeResult(1'b1, dst0, idx0, 1'b1, {rnd(), rnd()});
        results[1] = makeResult(1'b1, dst1, idx1, 1'b1, {rnd(), rnd()});
        step();
        idleInputs();
        recovery.inRecovery = 1'b1;
        recovery.flushHead  = head;
        recovery.flushTail  = tail;
        step();
        readBack(dst0, idx0);
        readBack(dst1, idx1);
    endtask

    task automatic randomCycle();
        fpResult r0;
        fpResult r1;
        r0 = makeResult((rnd() % 5) != 0, phyRegNum'(rnd()), alPtr'(rnd()),
                        (rnd() % 4) != 0, {rnd(), rnd()});
        r1 = r0;
        r0.valid     = (rnd() % 4) != 0;
        r1.valid     = (rnd() % 4) != 0;
        r1.writeReg  = (rnd() % 5) != 0;
        r1.dataValid = (rnd() % 4) != 0;
        r1.data      = {rnd(), rnd()};
        // Slot 1 never shares a destination or an entry with slot 0
        r1.phyDst  = phyRegNum'(r0.phyDst + phyRegNum'(1 + rnd() % 63));
        r1.alIndex = alPtr'(r0.alIndex + alPtr'(1 + rnd() % 31));
        results[0] = r0;
        results[1] = r1;
        stall = (rnd() % 6) == 0;
        clear = (rnd() % 10) == 0;
        recovery.inRecovery = (rnd() % 4) == 0;
        recovery.flushHead  = alPtr'(rnd());
        recovery.flushTail  = alPtr'(rnd());
        allocIndex = alPtr'(rnd());
        allocValid = ((rnd() % 3) == 0) && !completesAt(allocIndex);
        readNum    = ((rnd() % 2) == 0) ? lastReg : phyRegNum'(rnd());
        queryIndex = ((rnd() % 2) == 0) ? lastEntry : alPtr'(rnd());
        step();
    endtask

    // Compare against the state before this edge, then advance the model
    always @(posedge ctrl) begin
        if (!rst) begin
            checkEq(readData, refRegs[readNum], $sformatf("register %0d", readNum));
            checkEq(64'(queryState), 64'(refState[queryIndex]),
                    $sformatf("active list entry %0d", queryIndex));
        end
        if (rst) begin
            for (int r = 0; r < PHY_REG_NUM; r++) begin
                refRegs[r] = '0;
            end
            for (int e = 0; e < AL_ENTRY_NUM; e++) begin
                refState[e] = EXEC_NOT_FINISHED;
            end
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                refHeld[s] = '0;
            end
            lastReg   = '0;
            lastEntry = '0;
        end else begin
            if (allocValid) begin
                refState[allocIndex] = EXEC_NOT_FINISHED;
            end
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                if (slotUpdates(refHeld[s], stall, clear, recovery)) begin
                    if (refHeld[s].writeReg) begin
                        refRegs[refHeld[s].phyDst] = refHeld[s].data;
                        lastReg = refHeld[s].phyDst;
                    end
                    refState[refHeld[s].alIndex] =
                        refHeld[s].dataValid ? EXEC_SUCCESS : EXEC_NOT_FINISHED;
                    lastEntry = refHeld[s].alIndex;
                end
            end
            if (!stall) begin
                refHeld = results;
            end
        end
    end

    initial begin
        seed   = 32'h5aa05fff;
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        idleInputs();
        readNum    = '0;
        queryIndex = '0;
        // Ten rising edges with reset high
        for (int i = 0; i < 10; i++) begin
            @(posedge ctrl);
        end
        step();
        rst = 1'b0;
        for (int i = 0; i < 8; i++) begin
            readBack(phyRegNum'(rnd()), alPtr'(rnd()));
        end

        // Plain write, a result without destination, then a result without data
        idleInputs();
        results[0] = makeResult(1'b1, 6'd5, 5'd3, 1'b1, 64'h3ff0_0000_0000_0000);
        results[1] = makeResult(1'b0, 6'd6, 5'd4, 1'b1, 64'h4014_0000_0000_0000);
        step();
        readBack(6'd5, 5'd3);
        readBack(6'd5, 5'd3);
        readBack(6'd6, 5'd4);
        results[0] = makeResult(1'b1, 6'd8, 5'd3, 1'b0, 64'hc000_0000_0000_0000);
        step();
        readBack(6'd8, 5'd3);
        readBack(6'd8, 5'd3);
        allocValid = 1'b1;
        allocIndex = 5'd4;
        step();
        readBack(6'd6, 5'd4);

        // Stall holds the register and drops new inputs
        idleInputs();
        results[0] = makeResult(1'b1, 6'd10, 5'd10, 1'b1, 64'h4000_0000_0000_0000);
        results[1] = makeResult(1'b1, 6'd11, 5'd11, 1'b1, 64'h4008_0000_0000_0000);
        step();
        for (int i = 0; i < 4; i++) begin
            results[0] = makeResult(1'b1, 6'd12, 5'd12, 1'b1, 64'hdead_beef_0000_0001);
            results[1] = makeResult(1'b1, 6'd13, 5'd13, 1'b0, 64'hdead_beef_0000_0002);
            stall      = 1'b1;
            readNum    = 6'd10;
            queryIndex = 5'd11;
            step();
        end
        readBack(6'd11, 5'd11);
        readBack(6'd10, 5'd10);
        readBack(6'd11, 5'd11);
        readBack(6'd12, 5'd12);
        readBack(6'd13, 5'd13);

        // Clear in the write cycle drops the held result
        idleInputs();
        results[0] = makeResult(1'b1, 6'd20, 5'd20, 1'b1, 64'h4010_0000_0000_0000);
        step();
        idleInputs();
        clear = 1'b1;
        step();
        readBack(6'd20, 5'd20);

        // Non-wrapping, wrapping and empty flush ranges
        recoveryCase(5'd5, 5'd14, 5'd6, 6'd30, 5'd14, 6'd31);
        recoveryCase(5'd28, 5'd2, 5'd30, 6'd32, 5'd2, 6'd33);
        recoveryCase(5'd9, 5'd9, 5'd9, 6'd34, 5'd27, 6'd35);

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            randomCycle();
        end
        readBack(lastReg, lastEntry);
        readBack(lastReg, lastEntry);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tbFpWriteback

// File: flist.f
common/fpWbPkg.sv
fpRegWrite/flushRangeDetector.sv
fpRegWrite/fpRegWriteStage.sv
src/fpPhyRegFile.sv
src/activeListExecState.sv
src/fpWritebackTop.sv
test/tbFpWriteback.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the FP write-back testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tbFpWriteback -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

output=$(./obj_dir/VtbFpWriteback)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
